/* fetch_unit.f */
fetch_pkg.sv
pc_reg.sv
instr_mem.sv
if_stage.sv
if_id_reg.sv
fetch_unit.sv
tb_fetch_unit.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - fetch_pkg.sv
  - pc_reg.sv
  - instr_mem.sv
  - if_stage.sv
  - if_id_reg.sv
  - fetch_unit.sv
  - target: test
    files:
      - tb_fetch_unit.sv

/* tb_fetch_unit.sv */
module tb_fetch_unit
    import fetch_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 400;                // Well above the scenario length

    logic   clk = 1'b0;
    logic   rst_n;
    logic   enable;
    logic   halt;
    logic   stall;
    logic   flush;
    logic   clear;
    logic   jump;
    logic   load_valid;
    pc_t    jump_pc;
    instr_t load_word;
    if_id_t if_id;                                  // DUT latch output
    logic   full_mem;
    logic   empty_mem;

    integer seed = 32'hf28;                         // Fixed seed for $random
    int     cycles = 0;                             // Timeout counter
    int     fail_count = 0;

    // Reference model state
    instr_t ref_mem [MEM_WORDS];                    // Copy of the loaded program
    int     ref_count;                              // Loaded words
    pc_t    ref_pc;                                 // Expected PC
    if_id_t exp_if_id;                              // Expected latch contents

    fetch_unit dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_enable     (enable),
        .i_halt       (halt),
        .i_stall      (stall),
        .i_flush      (flush),
        .i_clear      (clear),
        .i_jump       (jump),
        .i_load_valid (load_valid),
        .i_jump_pc    (jump_pc),
        .i_load_word  (load_word),
        .o_if_id      (if_id),
        .o_full_mem   (full_mem),
        .o_empty_mem  (empty_mem)
    );

    always #2 clk = ~clk;                           // 4 ns period

    // Word at a byte address, zero past the loaded program
    function automatic instr_t ref_read(input pc_t pc);
        int unsigned idx;
        idx = pc / WORD_BYTES;
        if (idx < ref_count) begin
            return ref_mem[idx];
        end
        return '0;
    endfunction

    // PC after one edge, first matching rule wins
    function automatic pc_t ref_next_pc(input pc_t pc, input logic restart, input logic hold,
                                        input logic take_jump, input pc_t target);
        if (restart) return '0;
        if (hold) return pc;
        return take_jump ? target : pc + WORD_BYTES;
    endfunction

    // Latch contents after one edge
    function automatic if_id_t ref_next_latch(input if_id_t cur, input pc_t pc,
                                              input logic restart, input logic hold);
        if_id_t nxt;
        if (restart) return '0;                     // Bubble
        if (hold) return cur;
        nxt.valid       = 1'b1;
        nxt.pc          = pc;
        nxt.next_seq_pc = pc + WORD_BYTES;
        nxt.instr       = ref_read(pc);             // Read sees the count before this edge
        return nxt;
    endfunction

    // Model steps on the same edge as the DUT
    always @(posedge clk or negedge rst_n) begin
        logic restart;
        logic hold;
        if (!rst_n) begin
            ref_count = 0;
            ref_pc    = '0;
            exp_if_id = '0;
        end else begin
            restart   = flush || clear;
            hold      = !enable || halt || stall;
            exp_if_id = ref_next_latch(exp_if_id, ref_pc, restart, hold);
            ref_pc    = ref_next_pc(ref_pc, restart, hold, jump, jump_pc);
            if (clear) begin
                ref_count = 0;                      // Old words become unreachable
            end else if (load_valid && ref_count < MEM_WORDS) begin
                ref_mem[ref_count] = load_word;
                ref_count++;
            end
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            fail_count++;
            $display("[ERROR] %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Outputs are stable mid-cycle
    always @(negedge clk) begin
        compare_value("o_if_id.valid", 32'(if_id.valid), 32'(exp_if_id.valid));
        compare_value("o_if_id.pc", if_id.pc, exp_if_id.pc);
        compare_value("o_if_id.next_seq_pc", if_id.next_seq_pc, exp_if_id.next_seq_pc);
        compare_value("o_if_id.instr", if_id.instr, exp_if_id.instr);
        compare_value("o_full_mem", 32'(full_mem), 32'(ref_count == MEM_WORDS));
        compare_value("o_empty_mem", 32'(empty_mem), 32'(ref_count == 0));
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;                                         // Drive just after the edge
    endtask

    task automatic run_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic load_words(input int n);
        repeat (n) begin
            load_valid = 1'b1;
            load_word  = $random(seed);
            next_cycle();
        end
        load_valid = 1'b0;
    endtask

    task automatic jump_to_random();
        jump    = 1'b1;
        jump_pc = pc_t'($random(seed)) & 32'h0000_007c;  // Aligned, some past the memory
        next_cycle();
        jump    = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        enable     = 1'b0;
        halt       = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        clear      = 1'b0;
        jump       = 1'b0;
        load_valid = 1'b0;
        jump_pc    = '0;
        load_word  = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        load_words(10);                             // Partial program, PC parked
        enable = 1'b1;
        run_cycles(14);                             // Walk past the loaded words

        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        run_cycles(4);

        load_words(6);                              // Fill up while fetching
        run_cycles(4);

        repeat (3) begin
            jump_to_random();
            run_cycles(3);
        end

        stall = 1'b1;
        jump_to_random();                           // Hold beats the jump
        run_cycles(2);
        stall = 1'b0;
        run_cycles(2);
        halt = 1'b1;
        run_cycles(3);
        halt = 1'b0;
        run_cycles(2);
        enable = 1'b0;
        run_cycles(3);
        enable = 1'b1;
        run_cycles(2);

        stall = 1'b1;
        flush = 1'b1;                               // Flush beats the stall
        next_cycle();
        flush = 1'b0;
        stall = 1'b0;
        run_cycles(3);

        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        run_cycles(6);                              // Everything reads as zero now

        load_words(4);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        run_cycles(6);

        run_cycles(2);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* fetch_unit.sv */
module fetch_unit
    import fetch_pkg::*;
(
    input  logic   i_clk,                           // System clock
    input  logic   i_rst_n,                         // Async reset
    input  logic   i_enable,                        // Fetch enable
    input  logic   i_halt,                          // Processor halted
    input  logic   i_stall,                         // Hazard stall
    input  logic   i_flush,                         // Flush from a later stage
    input  logic   i_clear,                         // Clear program memory
    input  logic   i_jump,                          // Jump select
    input  logic   i_load_valid,                    // Host load strobe
    input  pc_t    i_jump_pc,                       // Jump target
    input  instr_t i_load_word,                     // Host load word
    output if_id_t o_if_id,                         // IF/ID latch output
    output logic   o_full_mem,                      // Memory full
    output logic   o_empty_mem                      // Memory empty
);

    if_id_t fetch_bundle;                           // Combinational fetch result

    if_stage u_if_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_halt       (i_halt),
        .i_stall      (i_stall),
        .i_flush      (i_flush),
        .i_clear      (i_clear),
        .i_jump       (i_jump),
        .i_load_valid (i_load_valid),
        .i_jump_pc    (i_jump_pc),
        .i_load_word  (i_load_word),
        .o_fetch      (fetch_bundle),
        .o_full_mem   (o_full_mem),
        .o_empty_mem  (o_empty_mem)
    );

    if_id_reg u_if_id_reg (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_enable (i_enable),
        .i_halt   (i_halt),
        .i_stall  (i_stall),
        .i_flush  (i_flush),
        .i_clear  (i_clear),
        .i_fetch  (fetch_bundle),
        .o_if_id  (o_if_id)
    );

endmodule

/* if_id_reg.sv */
module if_id_reg
    import fetch_pkg::*;
(
    input  logic   i_clk,                           // System clock
    input  logic   i_rst_n,                         // Async reset
    input  logic   i_enable,                        // Pipeline enable
    input  logic   i_halt,                          // Processor halted
    input  logic   i_stall,                         // Hazard stall
    input  logic   i_flush,                         // Insert a bubble
    input  logic   i_clear,                         // Program cleared
    input  if_id_t i_fetch,                         // Bundle from the fetch stage
    output if_id_t o_if_id                          // Latched bundle for decode
);

    if_id_t if_id_q;                                // Latch contents
    logic   hold;                                   // Keep the current contents

    assign hold = !i_enable || i_halt || i_stall;   // Mirrors the PC hold

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            if_id_q <= '0;                          // Invalid after reset
        end else if (i_flush || i_clear) begin
            if_id_q <= '0;                          // Bubble
        end else if (!hold) begin
            if_id_q <= i_fetch;                     // Bundle arrives marked valid
        end
    end

    assign o_if_id = if_id_q;

    // Successor is computed in the fetch stage and must still match here
    a_seq_pc : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_if_id.valid |-> (o_if_id.next_seq_pc == o_if_id.pc + PC_WIDTH'(WORD_BYTES))
    ) else $error("if_id_reg: next_seq_pc does not follow pc");

endmodule

/* if_stage.sv */
module if_stage
    import fetch_pkg::*;
(
    input  logic   i_clk,                           // System clock
    input  logic   i_rst_n,                         // Async reset
    input  logic   i_enable,                        // Fetch enable
    input  logic   i_halt,                          // Processor halted
    input  logic   i_stall,                         // Hazard stall
    input  logic   i_flush,                         // Restart fetch at 0
    input  logic   i_clear,                         // Empty memory and reset PC
    input  logic   i_jump,                          // Take the jump target
    input  logic   i_load_valid,                    // Load strobe
    input  pc_t    i_jump_pc,                       // Jump target
    input  instr_t i_load_word,                     // Word to load
    output if_id_t o_fetch,                         // Bundle for the IF/ID latch
    output logic   o_full_mem,                      // Memory full
    output logic   o_empty_mem                      // Memory empty
);

    pc_t    pc;                                     // Current fetch address
    pc_t    seq_pc;                                 // PC+4
    pc_t    next_pc;                                // Address for the next edge
    instr_t instr;                                  // Word at pc

    assign seq_pc  = pc + PC_WIDTH'(WORD_BYTES);    // Sequential step
    assign next_pc = i_jump ? i_jump_pc : seq_pc;   // Next PC mux

    pc_reg u_pc_reg (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_flush   (i_flush),
        .i_clear   (i_clear),
        .i_halt    (i_halt),
        .i_stall   (i_stall),
        .i_enable  (i_enable),
        .i_next_pc (next_pc),
        .o_pc      (pc)
    );

    instr_mem u_instr_mem (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_write     (i_load_valid),
        .i_clear     (i_clear),
        .i_word      (i_load_word),
        .i_pc        (pc),                          // Same cycle read
        .o_instr     (instr),
        .o_full_mem  (o_full_mem),
        .o_empty_mem (o_empty_mem)
    );

    // Latch decides whether this bundle is taken
    assign o_fetch = '{
        valid:       1'b1,
        pc:          pc,
        next_seq_pc: seq_pc,
        instr:       instr
    };

endmodule

/* instr_mem.sv */
module instr_mem
    import fetch_pkg::*;
(
    input  logic   i_clk,                           // System clock
    input  logic   i_rst_n,                         // Async reset
    input  logic   i_write,                         // Load strobe from the host
    input  logic   i_clear,                         // Empty the memory
    input  instr_t i_word,                          // Word to load
    input  pc_t    i_pc,                            // Fetch address in bytes
    output instr_t o_instr,                         // Fetched word
    output logic   o_full_mem,                      // All MEM_WORDS slots loaded
    output logic   o_empty_mem                      // Nothing loaded
);

    instr_t mem [MEM_WORDS];                        // Program storage
    waddr_t count;                                  // Loaded words and next write slot
    logic   wr_en;                                  // Accepted load strobe
    pc_t    rd_idx;                                 // Word index of the fetch address
    logic   rd_hit;                                 // Index lies inside the loaded program

    // Clear takes priority over a load in the same cycle
    assign wr_en = i_write && !o_full_mem && !i_clear;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;                            // Start empty
        end else if (i_clear) begin
            count <= '0;                            // Old words stay but read as zero
        end else if (wr_en) begin
            count <= count + waddr_t'(1);           // Advance load pointer
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[count[ADDR_WIDTH-1:0]] <= i_word;   // Write at the load pointer
        end
    end

    // Flags follow the count on the same edge
    assign o_full_mem  = (count == waddr_t'(MEM_WORDS));
    assign o_empty_mem = (count == '0);

    // Combinational read
    assign rd_idx  = i_pc / PC_WIDTH'(WORD_BYTES);  // Byte address to word index
    assign rd_hit  = (rd_idx < PC_WIDTH'(count));   // Count never exceeds MEM_WORDS
    assign o_instr = rd_hit ? mem[rd_idx[ADDR_WIDTH-1:0]] : '0;  // Zero word is a no-op

    // Host has no back-pressure so it must watch the full flag
    a_no_write_full : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_write |-> !o_full_mem
    ) else $error("instr_mem: load strobe while memory is full");

    a_flags_exclusive : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_full_mem && o_empty_mem)
    ) else $error("instr_mem: full and empty both set");

endmodule

/* pc_reg.sv */
module pc_reg
    import fetch_pkg::*;
(
    input  logic i_clk,                             // System clock
    input  logic i_rst_n,                           // Async reset
    input  logic i_flush,                           // Restart fetch at address 0
    input  logic i_clear,                           // Program cleared by the host
    input  logic i_halt,                            // Processor halted
    input  logic i_stall,                           // Hazard stall from later stages
    input  logic i_enable,                          // Fetch enable
    input  pc_t  i_next_pc,                         // Selected next address
    output pc_t  o_pc                               // Current fetch address
);

    pc_t pc_q;                                      // PC register
    logic hold;                                     // Freeze this cycle

    assign hold = !i_enable || i_halt || i_stall;   // Any of these keeps the PC

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= '0;                             // Boot from address 0
        end else if (i_clear || i_flush) begin
            pc_q <= '0;                             // Restart beats every hold
        end else if (hold) begin
            pc_q <= pc_q;
        end else begin
            pc_q <= i_next_pc;                      // Jump target or PC+4
        end
    end

    assign o_pc = pc_q;

    // Jump targets come from outside so alignment is not guaranteed locally
    a_pc_aligned : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_pc % PC_WIDTH'(WORD_BYTES)) == '0
    ) else $error("pc_reg: PC 0x%08h is not word aligned", o_pc);

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    // Datapath and memory geometry
    localparam int PC_WIDTH   = 32;                 // Program counter width in bits
    localparam int WORD_BYTES = 4;                  // Bytes per instruction word
    localparam int MEM_WORDS  = 16;                 // Instruction memory depth in words
    localparam int ADDR_WIDTH = 4;                  // Word index width for MEM_WORDS

    // Vector types
    typedef logic [PC_WIDTH-1:0] pc_t;              // Byte address
    typedef logic [31:0]         instr_t;           // One instruction word
    typedef logic [ADDR_WIDTH:0] waddr_t;           // Load pointer up to MEM_WORDS

    // Payload handed from fetch to decode
    typedef struct packed {
        logic   valid;                              // Low marks a bubble
        pc_t    pc;                                 // Address of the fetched word
        pc_t    next_seq_pc;                        // Sequential successor PC+4
        instr_t instr;                              // Fetched word
    } if_id_t;

endpackage
